// ==== rv_isa_pkg.sv ====
/*
 * RV32 ISA encodings with base word types, instruction field
 * positions, major opcodes and the instruction format enumeration
 */
package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    //////////////////////////////////////////////////
    // Instruction field positions
    //////////////////////////////////////////////////

    localparam int OPCODE_MSB = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int F3_LSB     = 12;
    localparam int F3_MSB     = 14;
    localparam int RS1_LSB    = 15;
    localparam int RS1_MSB    = 19;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;
    localparam int F7_LSB     = 25;
    localparam int F7_MSB     = 31;

    //////////////////////////////////////////////////
    // Major opcodes
    //////////////////////////////////////////////////

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // ADDI x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

    // Format decides immediate layout and which source registers are read
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J
    } format_e;

endpackage

// ==== decode_op_pkg.sv ====
/*
 * Execute operation codes produced by decode, and the datapath word type
 */
package decode_op_pkg;

    import rv_isa_pkg::*;

    // One datapath word, same width as the integer registers
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [5:0] {
        NOP,
        // Integer ALU
        LUI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        // Control transfer
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR,
        // Memory
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        // M extension
        MUL,
        MULH,
        MULHSU,
        MULHU,
        DIV,
        DIVU,
        REM,
        REMU,
        // Privileged and CSR
        ECALL,
        EBREAK,
        MRET,
        SRET,
        WFI,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        INVALID
    } op_e;

endpackage

// ==== instr_replay.sv ====
/*
 * Holds the last decoded instruction and replays it after a stall or hazard
 */
`timescale 1ns/1ps

module instr_replay
    import rv_isa_pkg::*;
(
    input  logic   clk,
    input  logic   reset_n,
    input  logic   enable_i,
    input  logic   hazard_i,
    input  instr_t instr_i,
    output instr_t cur_instr_o
);

    instr_t held_instr;
    logic   last_hazard;
    logic   last_stall;

    // Held word follows whatever was decoded this cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            held_instr <= NOP_INSTR;
        end else begin
            held_instr <= cur_instr_o;
        end
    end

    // Both flags start set so the first decode sees the held NOP
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_hazard <= 1'b1;
            last_stall  <= 1'b1;
        end else begin
            last_hazard <= hazard_i;
            last_stall  <= !enable_i;
        end
    end

    assign cur_instr_o = (last_hazard || last_stall) ? held_instr : instr_i;

endmodule

// ==== op_decoder.sv ====
/*
 * RV32I/M operation decoder with instruction format and illegal flag
 */
`timescale 1ns/1ps

module op_decoder
    import rv_isa_pkg::*;
    import decode_op_pkg::*;
#(
    parameter bit M_ENABLE = 1'b1
) (
    input  instr_t  instr_i,
    output op_e     operation_o,
    output format_e format_o,
    output logic    illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       sys_regs_zero;

    op_e dec_branch;
    op_e dec_load;
    op_e dec_store;
    op_e dec_op_imm;
    op_e dec_op;
    op_e dec_mul;
    op_e dec_misc_mem;
    op_e dec_system;

    assign opcode = instr_i[OPCODE_MSB:0];
    assign funct3 = instr_i[F3_MSB:F3_LSB];
    assign funct7 = instr_i[F7_MSB:F7_LSB];

    //////////////////////////////////////////////////
    // Per-group decode
    //////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  dec_branch = BEQ;
            3'b001:  dec_branch = BNE;
            3'b100:  dec_branch = BLT;
            3'b101:  dec_branch = BGE;
            3'b110:  dec_branch = BLTU;
            3'b111:  dec_branch = BGEU;
            default: dec_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_load = LB;
            3'b001:  dec_load = LH;
            3'b010:  dec_load = LW;
            3'b100:  dec_load = LBU;
            3'b101:  dec_load = LHU;
            default: dec_load = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_store = SB;
            3'b001:  dec_store = SH;
            3'b010:  dec_store = SW;
            default: dec_store = INVALID;
        endcase
    end

    // Shift-immediates are the only OP-IMM encodings that constrain funct7
    always_comb begin
        dec_op_imm = INVALID;
        case (funct3)
            3'b000: dec_op_imm = ADD;
            3'b010: dec_op_imm = SLT;
            3'b011: dec_op_imm = SLTU;
            3'b100: dec_op_imm = XOR;
            3'b110: dec_op_imm = OR;
            3'b111: dec_op_imm = AND;
            3'b001: begin
                if (funct7 == 7'b0000000) dec_op_imm = SLL;
            end
            default: begin
                if (funct7 == 7'b0000000) dec_op_imm = SRL;
                else if (funct7 == 7'b0100000) dec_op_imm = SRA;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  dec_mul = MUL;
            3'b001:  dec_mul = MULH;
            3'b010:  dec_mul = MULHSU;
            3'b011:  dec_mul = MULHU;
            3'b100:  dec_mul = DIV;
            3'b101:  dec_mul = DIVU;
            3'b110:  dec_mul = REM;
            default: dec_mul = REMU;
        endcase
    end

    always_comb begin
        dec_op = INVALID;
        case (funct7)
            7'b0000000: begin
                case (funct3)
                    3'b000:  dec_op = ADD;
                    3'b001:  dec_op = SLL;
                    3'b010:  dec_op = SLT;
                    3'b011:  dec_op = SLTU;
                    3'b100:  dec_op = XOR;
                    3'b101:  dec_op = SRL;
                    3'b110:  dec_op = OR;
                    default: dec_op = AND;
                endcase
            end
            7'b0100000: begin
                if (funct3 == 3'b000) dec_op = SUB;
                else if (funct3 == 3'b101) dec_op = SRA;
            end
            7'b0000001: begin
                if (M_ENABLE) dec_op = dec_mul;
            end
            default: dec_op = INVALID;
        endcase
    end

    // Only FENCE is accepted, and it does nothing in this core
    always_comb begin
        if (funct3 == 3'b000) dec_misc_mem = NOP;
        else dec_misc_mem = INVALID;
    end

    // ECALL, EBREAK, xRET and WFI need rs1 and rd cleared
    assign sys_regs_zero = (instr_i[RS1_MSB:RS1_LSB] == '0) && (instr_i[RD_MSB:RD_LSB] == '0);

    always_comb begin
        dec_system = INVALID;
        case (funct3)
            3'b000: begin
                if (sys_regs_zero) begin
                    // funct12 field
                    case (instr_i[31:20])
                        12'h000: dec_system = ECALL;
                        12'h001: dec_system = EBREAK;
                        12'h102: dec_system = SRET;
                        12'h302: dec_system = MRET;
                        12'h105: dec_system = WFI;
                        default: dec_system = INVALID;
                    endcase
                end
            end
            3'b001:  dec_system = CSRRW;
            3'b010:  dec_system = CSRRS;
            3'b011:  dec_system = CSRRC;
            3'b101:  dec_system = CSRRWI;
            3'b110:  dec_system = CSRRSI;
            3'b111:  dec_system = CSRRCI;
            default: dec_system = INVALID;
        endcase
    end

    //////////////////////////////////////////////////
    // Opcode select and format
    //////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_LUI:      operation_o = LUI;
            OPC_AUIPC:    operation_o = ADD;
            OPC_JAL:      operation_o = JAL;
            OPC_JALR:     operation_o = JALR;
            OPC_BRANCH:   operation_o = dec_branch;
            OPC_LOAD:     operation_o = dec_load;
            OPC_STORE:    operation_o = dec_store;
            OPC_OP_IMM:   operation_o = dec_op_imm;
            OPC_OP:       operation_o = dec_op;
            OPC_MISC_MEM: operation_o = dec_misc_mem;
            OPC_SYSTEM:   operation_o = dec_system;
            default:      operation_o = INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: format_o = FMT_I;
            OPC_STORE:                      format_o = FMT_S;
            OPC_BRANCH:                     format_o = FMT_B;
            OPC_LUI, OPC_AUIPC:             format_o = FMT_U;
            OPC_JAL:                        format_o = FMT_J;
            default:                        format_o = FMT_R;
        endcase
    end

    assign illegal_o = (operation_o == INVALID);

endmodule

// ==== imm_gen.sv ====
/*
 * Sign-extended immediate builder for the I, S, B, U and J formats
 */
`timescale 1ns/1ps

module imm_gen
    import rv_isa_pkg::*;
    import decode_op_pkg::*;
(
    input  instr_t  instr_i,
    input  format_e format_i,
    output word_t   imm_o
);

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    // Bit 31 is always the sign
    assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};

    assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};

    // Branch and jump offsets are in halfwords
    assign imm_b = {
        {20{instr_i[31]}},
        instr_i[7],
        instr_i[30:25],
        instr_i[11:8],
        1'b0
    };

    assign imm_u = {instr_i[31:12], 12'b0};

    assign imm_j = {
        {12{instr_i[31]}},
        instr_i[19:12],
        instr_i[20],
        instr_i[30:21],
        1'b0
    };

    always_comb begin
        case (format_i)
            FMT_I:   imm_o = imm_i;
            FMT_S:   imm_o = imm_s;
            FMT_B:   imm_o = imm_b;
            FMT_U:   imm_o = imm_u;
            FMT_J:   imm_o = imm_j;
            // R format carries no immediate
            default: imm_o = '0;
        endcase
    end

endmodule

// ==== hazard_unit.sv ====
/*
 * Destination register and store lock tracking with hazard detection
 */
`timescale 1ns/1ps

module hazard_unit
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      enable_i,
    input  logic      jumped_i,
    input  instr_t    instr_i,
    input  format_e   format_i,
    output logic      hazard_o,
    output reg_addr_t locked_rd_o
);

    logic      locked_mem;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_rs1;
    logic      use_rs2;
    logic      use_mem;
    logic      hit_rs1;
    logic      hit_rs2;
    logic      hit_mem;

    assign rs1 = instr_i[RS1_MSB:RS1_LSB];
    assign rs2 = instr_i[RS2_MSB:RS2_LSB];

    //////////////////////////////////////////////////
    // Lock of the instruction now in execute
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_rd_o <= '0;
            locked_mem  <= 1'b0;
        end else if (hazard_o) begin
            locked_rd_o <= '0;
            locked_mem  <= 1'b0;
        end else if (enable_i) begin
            locked_rd_o <= instr_i[RD_MSB:RD_LSB];
            locked_mem  <= (instr_i[OPCODE_MSB:0] == OPC_STORE);
        end
    end

    // Source use by format
    always_comb begin
        case (format_i)
            FMT_R, FMT_B, FMT_S: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            FMT_I: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b0;
            end
            default: begin
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
            end
        endcase
    end

    assign use_mem = (instr_i[OPCODE_MSB:0] == OPC_LOAD);

    // x0 never matches a lock
    assign hit_rs1 = use_rs1 && (rs1 != '0) && (rs1 == locked_rd_o);
    assign hit_rs2 = use_rs2 && (rs2 != '0) && (rs2 == locked_rd_o);
    assign hit_mem = use_mem && locked_mem;

    assign hazard_o = (hit_rs1 || hit_rs2 || hit_mem) && enable_i && !jumped_i;

endmodule

// ==== decode_stage.sv ====
/*
 * Decode stage top with operand select, misaligned fetch check
 * and the registered outputs towards execute
 */
`timescale 1ns/1ps

module decode_stage
    import rv_isa_pkg::*;
    import decode_op_pkg::*;
#(
    parameter bit M_ENABLE = 1'b1,
    parameter bit C_ALIGN  = 1'b0
) (
    input  logic      clk,
    input  logic      reset_n,
    input  logic      enable_i,
    input  logic      jumped_i,
    input  instr_t    instr_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output reg_addr_t rd_o,
    output word_t     first_operand_o,
    output word_t     second_operand_o,
    output word_t     third_operand_o,
    output word_t     pc_o,
    output instr_t    instr_o,
    output op_e       operation_o,
    output logic      hazard_o,
    output logic      exc_illegal_o,
    output logic      exc_misaligned_o
);

    instr_t    cur_instr;
    op_e       operation;
    format_e   instr_format;
    logic      illegal;
    logic      misaligned;
    word_t     immediate;
    reg_addr_t locked_rd;
    word_t     first_operand;
    word_t     second_operand;
    word_t     third_operand;

    instr_replay i_replay (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .hazard_i    (hazard_o),
        .instr_i     (instr_i),
        .cur_instr_o (cur_instr)
    );

    op_decoder #(
        .M_ENABLE (M_ENABLE)
    ) i_decoder (
        .instr_i     (cur_instr),
        .operation_o (operation),
        .format_o    (instr_format),
        .illegal_o   (illegal)
    );

    imm_gen i_imm (
        .instr_i  (cur_instr),
        .format_i (instr_format),
        .imm_o    (immediate)
    );

    hazard_unit i_hazard (
        .clk         (clk),
        .reset_n     (reset_n),
        .enable_i    (enable_i),
        .jumped_i    (jumped_i),
        .instr_i     (cur_instr),
        .format_i    (instr_format),
        .hazard_o    (hazard_o),
        .locked_rd_o (locked_rd)
    );

    // Register file is read in the same cycle
    assign rs1_addr_o = cur_instr[RS1_MSB:RS1_LSB];
    assign rs2_addr_o = cur_instr[RS2_MSB:RS2_LSB];

    //////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////

    assign first_operand  = (instr_format inside {FMT_U, FMT_J}) ? pc_i : rs1_data_i;
    assign second_operand = (instr_format inside {FMT_R, FMT_B}) ? rs2_data_i : immediate;
    // Store data rides on the third operand
    assign third_operand  = (instr_format == FMT_S) ? rs2_data_i : immediate;

    // Compressed code only needs halfword alignment
    assign misaligned = C_ALIGN ? pc_i[0] : (pc_i[1:0] != 2'b00);

    //////////////////////////////////////////////////
    // Output register towards execute
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            operation_o      <= NOP;
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (hazard_o) begin
            // Bubble
            operation_o      <= NOP;
            first_operand_o  <= '0;
            second_operand_o <= '0;
            third_operand_o  <= '0;
            pc_o             <= '0;
            instr_o          <= '0;
            exc_illegal_o    <= 1'b0;
            exc_misaligned_o <= 1'b0;
        end else if (enable_i) begin
            operation_o      <= operation;
            first_operand_o  <= first_operand;
            second_operand_o <= second_operand;
            third_operand_o  <= third_operand;
            pc_o             <= pc_i;
            instr_o          <= cur_instr;
            exc_illegal_o    <= illegal;
            exc_misaligned_o <= misaligned;
        end
    end

    // Writeback destination trails execute by one stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_o <= '0;
        end else if (enable_i) begin
            rd_o <= locked_rd;
        end
    end

endmodule

// ==== tb_decode_stage.sv ====
/*
 * Directed testbench for the decode stage with a reference decoder,
 * a register file model and a cycle timeout
 */
`timescale 1ns/1ps

module tb_decode_stage
    import rv_isa_pkg::*;
    import decode_op_pkg::*;
();

    // All tests together run for about 70 cycles
    localparam int    timeout_cycles = 2000;
    localparam word_t reg_scale      = 32'h0100_1001;

    localparam op_e alu_ops    [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    localparam op_e mul_ops    [8] = '{MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    localparam op_e branch_ops [8] = '{BEQ, BNE, INVALID, INVALID, BLT, BGE, BLTU, BGEU};
    localparam op_e load_ops   [8] = '{LB, LH, LW, INVALID, LBU, LHU, INVALID, INVALID};
    localparam op_e store_ops  [8] = '{SB, SH, SW, INVALID, INVALID, INVALID, INVALID, INVALID};
    localparam logic [6:0] imm_opcodes [5] = '{OPC_STORE, OPC_BRANCH, OPC_LUI, OPC_AUIPC, OPC_JAL};

    logic      clk;
    logic      reset_n;
    logic      enable_i;
    logic      jumped_i;
    instr_t    instr_i;
    word_t     pc_i;
    word_t     rs1_data_i;
    word_t     rs2_data_i;
    reg_addr_t rs1_addr_o;
    reg_addr_t rs2_addr_o;
    reg_addr_t rd_o;
    word_t     first_operand_o;
    word_t     second_operand_o;
    word_t     third_operand_o;
    word_t     pc_o;
    instr_t    instr_o;
    op_e       operation_o;
    logic      hazard_o;
    logic      exc_illegal_o;
    logic      exc_misaligned_o;

    int seed;
    int errors;
    int checks;
    int cycle_count = 0;

    decode_stage i_dut (.*);

    // Register file model returns the index times a constant
    function automatic word_t reg_value(input reg_addr_t idx);
        return {27'b0, idx} * reg_scale;
    endfunction

    assign rs1_data_i = reg_value(rs1_addr_o);
    assign rs2_data_i = reg_value(rs2_addr_o);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Encoders and reference decode
    //////////////////////////////////////////////////

    function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd, input logic [6:0] opcode);
        return {f7, rs2, rs1, f3, rd, opcode};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic format_e ref_format(input logic [6:0] opcode);
        case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: return FMT_I;
            OPC_STORE:                      return FMT_S;
            OPC_BRANCH:                     return FMT_B;
            OPC_LUI, OPC_AUIPC:             return FMT_U;
            OPC_JAL:                        return FMT_J;
            default:                        return FMT_R;
        endcase
    endfunction

    // Immediate layouts from the base ISA
    function automatic word_t ref_imm(input instr_t w, input format_e fmt);
        case (fmt)
            FMT_I:   return {{20{w[31]}}, w[31:20]};
            FMT_S:   return {{20{w[31]}}, w[31:25], w[11:7]};
            FMT_B:   return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            FMT_U:   return {w[31:12], 12'h000};
            FMT_J:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'd0;
        endcase
    endfunction

    function automatic op_e ref_op(input instr_t w);
        logic [2:0] f3;
        logic [6:0] f7;
        op_e        result;
        f3     = w[14:12];
        f7     = w[31:25];
        result = INVALID;
        case (w[6:0])
            OPC_LUI:    result = LUI;
            OPC_AUIPC:  result = ADD;
            OPC_JAL:    result = JAL;
            OPC_JALR:   result = JALR;
            OPC_BRANCH: result = branch_ops[f3];
            OPC_LOAD:   result = load_ops[f3];
            OPC_STORE:  result = store_ops[f3];
            OPC_OP_IMM: begin
                result = alu_ops[f3];
                if (f3 == 3'b001 && f7 != 7'b0000000) result = INVALID;
                if (f3 == 3'b101) begin
                    if (f7 == 7'b0100000) result = SRA;
                    else if (f7 != 7'b0000000) result = INVALID;
                end
            end
            OPC_OP: begin
                if (f7 == 7'b0000001) result = mul_ops[f3];
                else if (f7 == 7'b0000000) result = alu_ops[f3];
                else if (f7 == 7'b0100000 && f3 == 3'b000) result = SUB;
                else if (f7 == 7'b0100000 && f3 == 3'b101) result = SRA;
            end
            default: result = INVALID;
        endcase
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Drive and check helpers
    //////////////////////////////////////////////////

    task automatic compare(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    // Called 1 ns after a rising edge and returns 1 ns after the next one
    task automatic run_cycle(input string test, input instr_t instr, input word_t pc,
                             input logic exp_hazard);
        instr_i = instr;
        pc_i    = pc;
        #2;
        compare({test, " hazard"}, {31'b0, exp_hazard}, {31'b0, hazard_o});
        @(posedge clk);
        #1;
    endtask

    task automatic check_outputs(input string test, input instr_t instr, input word_t pc);
        format_e fmt;
        word_t   imm;
        word_t   rs1_val;
        word_t   rs2_val;
        op_e     exp_op;
        fmt     = ref_format(instr[6:0]);
        imm     = ref_imm(instr, fmt);
        rs1_val = reg_value(instr[19:15]);
        rs2_val = reg_value(instr[24:20]);
        exp_op  = ref_op(instr);
        compare({test, " operation"}, {26'b0, exp_op}, {26'b0, operation_o});
        compare({test, " first operand"},
                (fmt == FMT_U || fmt == FMT_J) ? pc : rs1_val, first_operand_o);
        compare({test, " second operand"},
                (fmt == FMT_R || fmt == FMT_B) ? rs2_val : imm, second_operand_o);
        compare({test, " third operand"}, (fmt == FMT_S) ? rs2_val : imm, third_operand_o);
        compare({test, " pc"}, pc, pc_o);
        compare({test, " instr"}, instr, instr_o);
        compare({test, " illegal"}, {31'b0, exp_op == INVALID}, {31'b0, exc_illegal_o});
        compare({test, " misaligned"}, {31'b0, pc[1:0] != 2'b00}, {31'b0, exc_misaligned_o});
    endtask

    task automatic check_bubble(input string test);
        compare({test, " operation"}, {26'b0, NOP}, {26'b0, operation_o});
        compare({test, " first operand"}, 32'd0, first_operand_o);
        compare({test, " second operand"}, 32'd0, second_operand_o);
        compare({test, " third operand"}, 32'd0, third_operand_o);
        compare({test, " pc"}, 32'd0, pc_o);
        compare({test, " instr"}, 32'd0, instr_o);
        compare({test, " exceptions"}, 32'd0, {30'b0, exc_illegal_o, exc_misaligned_o});
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    // Sources stay below x16 and destinations at x16 or above, so no lock is hit
    task automatic run_alu_decode();
        instr_t prog[$];
        word_t  rnd;
        int     f3;
        for (f3 = 0; f3 < 8; f3++) begin
            rnd = $random(seed);
            if (f3 == 1 || f3 == 5) rnd[11:5] = 7'b0000000;
            prog.push_back(enc_i(rnd[11:0], 5'(f3 + 1), 3'(f3), 5'(f3 + 16), OPC_OP_IMM));
            prog.push_back(enc_r(7'b0000000, 5'(f3 + 8), 5'(f3 + 1), 3'(f3), 5'(f3 + 16), OPC_OP));
            prog.push_back(enc_r(7'b0000001, 5'(f3 + 8), 5'(f3 + 1), 3'(f3), 5'(f3 + 24), OPC_OP));
        end
        prog.push_back(enc_i({7'b0100000, 5'd7}, 5'd9, 3'b101, 5'd24, OPC_OP_IMM));
        prog.push_back(enc_r(7'b0100000, 5'd3, 5'd2, 3'b000, 5'd25, OPC_OP));
        prog.push_back(enc_r(7'b0100000, 5'd5, 5'd4, 3'b101, 5'd26, OPC_OP));
        foreach (prog[k]) begin
            run_cycle("alu_decode", prog[k], 32'h100 + 4 * k, 1'b0);
            check_outputs("alu_decode", prog[k], 32'h100 + 4 * k);
        end
    endtask

    task automatic run_immediates();
        instr_t instr;
        word_t  pc;
        int     round;
        int     k;
        for (round = 0; round < 4; round++) begin
            for (k = 0; k < 5; k++) begin
                instr      = $random(seed);
                pc         = $random(seed);
                pc[1:0]    = 2'b00;
                instr[6:0] = imm_opcodes[k];
                if (imm_opcodes[k] == OPC_STORE) instr[14:12] = 3'b010;
                if (imm_opcodes[k] == OPC_BRANCH) instr[14:12] = 3'b001;
                // Keep the rd field high and both source fields low
                instr[11] = 1'b1;
                instr[19] = 1'b0;
                instr[24] = 1'b0;
                run_cycle("immediates", instr, pc, 1'b0);
                check_outputs("immediates", instr, pc);
            end
        end
    endtask

    task automatic run_exceptions();
        instr_t bad;
        instr_t addi;
        bad  = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd20, 7'b1111111);
        addi = enc_i(12'd4, 5'd1, 3'b000, 5'd21, OPC_OP_IMM);
        run_cycle("exceptions", bad, 32'h300, 1'b0);
        check_outputs("exceptions", bad, 32'h300);
        compare("exceptions illegal flag", 32'd1, {31'b0, exc_illegal_o});
        run_cycle("exceptions", addi, 32'h302, 1'b0);
        check_outputs("exceptions", addi, 32'h302);
        compare("exceptions misaligned flag", 32'd1, {31'b0, exc_misaligned_o});
        run_cycle("exceptions", addi, 32'h305, 1'b0);
        check_outputs("exceptions", addi, 32'h305);
        run_cycle("exceptions", addi, 32'h308, 1'b0);
        check_outputs("exceptions", addi, 32'h308);
    endtask

    task automatic run_register_hazard();
        instr_t addi_x5;
        instr_t add_x6;
        instr_t skipped;
        addi_x5 = enc_i(12'd7, 5'd2, 3'b000, 5'd5, OPC_OP_IMM);
        add_x6  = enc_r(7'b0000000, 5'd1, 5'd5, 3'b000, 5'd6, OPC_OP);
        skipped = enc_i(12'd1, 5'd3, 3'b000, 5'd7, OPC_OP_IMM);
        run_cycle("reg_hazard", addi_x5, 32'h200, 1'b0);
        check_outputs("reg_hazard", addi_x5, 32'h200);
        run_cycle("reg_hazard", add_x6, 32'h204, 1'b1);
        check_bubble("reg_hazard bubble");
        compare("reg_hazard rd", 32'd5, {27'b0, rd_o});
        // Fetch has moved on but the held ADD is decoded again
        run_cycle("reg_hazard", skipped, 32'h204, 1'b0);
        check_outputs("reg_hazard replay", add_x6, 32'h204);
        run_cycle("reg_hazard", addi_x5, 32'h300, 1'b0);
        jumped_i = 1'b1;
        run_cycle("reg_hazard jumped", add_x6, 32'h304, 1'b0);
        jumped_i = 1'b0;
        check_outputs("reg_hazard jumped", add_x6, 32'h304);
    endtask

    task automatic run_store_load();
        instr_t sw;
        instr_t lw;
        sw = enc_r(7'b0000000, 5'd2, 5'd3, 3'b010, 5'd8, OPC_STORE);
        lw = enc_i(12'd0, 5'd4, 3'b010, 5'd20, OPC_LOAD);
        run_cycle("store_load", sw, 32'h400, 1'b0);
        check_outputs("store_load", sw, 32'h400);
        run_cycle("store_load", lw, 32'h404, 1'b1);
        check_bubble("store_load bubble");
        run_cycle("store_load", NOP_INSTR, 32'h404, 1'b0);
        check_outputs("store_load replay", lw, 32'h404);
    endtask

    task automatic run_stall();
        instr_t first;
        instr_t held;
        instr_t later;
        first = enc_r(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd21, OPC_OP);
        held  = enc_i(12'h055, 5'd3, 3'b100, 5'd22, OPC_OP_IMM);
        later = enc_r(7'b0100000, 5'd4, 5'd5, 3'b000, 5'd23, OPC_OP);
        run_cycle("stall", first, 32'h500, 1'b0);
        check_outputs("stall", first, 32'h500);
        enable_i = 1'b0;
        run_cycle("stall", held, 32'h504, 1'b0);
        check_outputs("stall hold", first, 32'h500);
        run_cycle("stall", held, 32'h504, 1'b0);
        check_outputs("stall hold", first, 32'h500);
        enable_i = 1'b1;
        run_cycle("stall", later, 32'h504, 1'b0);
        check_outputs("stall resume", held, 32'h504);
        run_cycle("stall", later, 32'h508, 1'b0);
        check_outputs("stall resume", later, 32'h508);
    endtask

    initial begin
        seed     = 32'h7a6d;
        errors   = 0;
        checks   = 0;
        reset_n  = 1'b0;
        enable_i = 1'b1;
        jumped_i = 1'b0;
        instr_i  = NOP_INSTR;
        pc_i     = '0;
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        check_bubble("reset");
        compare("reset rd", 32'd0, {27'b0, rd_o});
        // First cycle out of reset decodes the held NOP
        run_cycle("reset", NOP_INSTR, '0, 1'b0);
        run_alu_decode();
        run_immediates();
        run_exceptions();
        run_register_hazard();
        run_store_load();
        run_stall();
        $display("Finished: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== decode_stage.f ====
rv_isa_pkg.sv
decode_op_pkg.sv
instr_replay.sv
op_decoder.sv
imm_gen.sv
hazard_unit.sv
decode_stage.sv
tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the decode stage testbench

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_decode_stage -f decode_stage.f -o tb_decode_stage \
    && ./obj_dir/tb_decode_stage > sim.log 2>&1 \
    || { echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qF "*** PASSED ***" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
